/* include/pad_ctrl_cfg.svh */
`ifndef PAD_CTRL_CFG_SVH
`define PAD_CTRL_CFG_SVH

// number of pads, also the width of every source group
`define PAD_CTRL_N_IO 16

// per-pad mux select width
`define PAD_CTRL_NBIT_PADMUX 2

// per-pad config word, drive strength and pull bits
`define PAD_CTRL_NBIT_PADCFG 6

// pad index field, wide enough to name pads past the last one
`define PAD_CTRL_IDX_W 5

`endif

/* source/pad_ctrl_pkg.sv */
`include "pad_ctrl_cfg.svh"

package pad_ctrl_pkg;

  // source group driving a pad
  typedef enum logic [`PAD_CTRL_NBIT_PADMUX-1:0] {
    MUX_OFF    = 2'd0,
    MUX_PERIO  = 2'd1,
    MUX_GPIO   = 2'd2,
    MUX_FPGAIO = 2'd3
  } pad_mux_e;

  typedef enum logic {
    CFG_WRITE = 1'b0,
    CFG_READ  = 1'b1
  } cfg_op_e;

  typedef struct packed {
    cfg_op_e                         op;
    logic [`PAD_CTRL_IDX_W-1:0]      idx;
    pad_mux_e                        mux;
    logic [`PAD_CTRL_NBIT_PADCFG-1:0] cfg;
  } cfg_req_t;

  typedef struct packed {
    logic                            err;
    pad_mux_e                        mux;
    logic [`PAD_CTRL_NBIT_PADCFG-1:0] cfg;
  } cfg_rsp_t;

  // one-cycle strobe from decode to the register bank
  typedef struct packed {
    logic                            wr;
    logic                            rd;
    logic                            err;
    logic [`PAD_CTRL_IDX_W-1:0]      idx;
    pad_mux_e                        mux;
    logic [`PAD_CTRL_NBIT_PADCFG-1:0] cfg;
  } decoded_t;

endpackage

/* source/pad_cfg_decode.sv */
`timescale 1ns/1ps

`include "pad_ctrl_cfg.svh"

module pad_cfg_decode (
  input  logic                    ref_clk_i,
  input  logic                    rst_i,
  input  logic                    req_valid_i,
  input  pad_ctrl_pkg::cfg_req_t  req_i,
  output logic                    req_ready_o,
  input  logic                    rsp_pending_i,
  input  logic                    rsp_accept_i,
  output pad_ctrl_pkg::decoded_t  dec_o
);

  localparam logic [`PAD_CTRL_IDX_W-1:0] NUM_PADS = `PAD_CTRL_N_IO;

  logic accept;
  logic out_of_range;
  logic is_write;

  // free when nothing pending, or the pending response leaves this cycle
  assign req_ready_o = ~rsp_pending_i | rsp_accept_i;
  assign accept      = req_valid_i & req_ready_o;

  assign out_of_range = (req_i.idx >= NUM_PADS);
  assign is_write     = (req_i.op == pad_ctrl_pkg::CFG_WRITE);

  always_comb begin
    dec_o     = '0;
    dec_o.idx = req_i.idx;
    dec_o.mux = req_i.mux;
    dec_o.cfg = req_i.cfg;
    if (accept) begin
      // bad index only reports an error, nothing is touched
      dec_o.err = out_of_range;
      dec_o.wr  = is_write & ~out_of_range;
      dec_o.rd  = ~is_write & ~out_of_range;
    end
  end

  // requester keeps the request steady until it is taken
  property p_req_hold;
    @(posedge ref_clk_i) disable iff (rst_i)
      (req_valid_i && !req_ready_o) |=> (req_valid_i && $stable(req_i));
  endproperty

  a_req_hold: assert property (p_req_hold)
    else $error("request changed while stalled");

endmodule

/* source/pad_cfg_regs.sv */
`timescale 1ns/1ps

`include "pad_ctrl_cfg.svh"

module pad_cfg_regs (
  input  logic                                              ref_clk_i,
  input  logic                                              rst_i,
  input  pad_ctrl_pkg::decoded_t                            dec_i,
  input  logic                                              rsp_ready_i,
  output logic                                              rsp_valid_o,
  output pad_ctrl_pkg::cfg_rsp_t                            rsp_o,
  output logic                                              rsp_pending_o,
  output logic                                              rsp_accept_o,
  output pad_ctrl_pkg::pad_mux_e [`PAD_CTRL_N_IO-1:0]       pad_mux_o,
  output logic [`PAD_CTRL_N_IO-1:0][`PAD_CTRL_NBIT_PADCFG-1:0] pad_cfg_o
);

  pad_ctrl_pkg::pad_mux_e [`PAD_CTRL_N_IO-1:0]          mux_q;
  logic [`PAD_CTRL_N_IO-1:0][`PAD_CTRL_NBIT_PADCFG-1:0] cfg_q;

  logic                   rsp_valid_q;
  pad_ctrl_pkg::cfg_rsp_t rsp_q;
  pad_ctrl_pkg::cfg_rsp_t rsp_d;
  logic                   strobe;

  assign strobe = dec_i.wr | dec_i.rd | dec_i.err;

  // settings per pad
  always_ff @(posedge ref_clk_i) begin
    if (rst_i) begin
      mux_q <= {`PAD_CTRL_N_IO{pad_ctrl_pkg::MUX_OFF}};
      cfg_q <= '0;
    end else if (dec_i.wr) begin
      mux_q[dec_i.idx] <= dec_i.mux;
      cfg_q[dec_i.idx] <= dec_i.cfg;
    end
  end

  always_comb begin
    rsp_d = '0;
    if (dec_i.err) begin
      rsp_d.err = 1'b1;
    end else if (dec_i.wr) begin
      rsp_d.mux = dec_i.mux;
      rsp_d.cfg = dec_i.cfg;
    end else if (dec_i.rd) begin
      rsp_d.mux = mux_q[dec_i.idx];
      rsp_d.cfg = cfg_q[dec_i.idx];
    end
  end

  always_ff @(posedge ref_clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else if (strobe) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_accept_o) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge ref_clk_i) begin
    if (strobe) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_valid_o   = rsp_valid_q;
  assign rsp_o         = rsp_q;
  assign rsp_pending_o = rsp_valid_q;
  assign rsp_accept_o  = rsp_valid_q & rsp_ready_i;
  assign pad_mux_o     = mux_q;
  assign pad_cfg_o     = cfg_q;

  a_rsp_hold: assert property (
    @(posedge ref_clk_i) disable iff (rst_i)
      (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o))
  ) else $error("response changed under back-pressure");

  // decode must not issue while the old response is still stuck
  a_no_overrun: assert property (
    @(posedge ref_clk_i) disable iff (rst_i)
      strobe |-> (!rsp_valid_q || rsp_ready_i)
  ) else $error("strobe while response pending");

endmodule

/* source/pad_mux_route.sv */
`timescale 1ns/1ps

`include "pad_ctrl_cfg.svh"

module pad_mux_route (
  input  pad_ctrl_pkg::pad_mux_e [`PAD_CTRL_N_IO-1:0] pad_mux_i,
  input  logic [`PAD_CTRL_N_IO-1:0]                   perio_out_i,
  input  logic [`PAD_CTRL_N_IO-1:0]                   perio_oe_i,
  input  logic [`PAD_CTRL_N_IO-1:0]                   gpio_out_i,
  input  logic [`PAD_CTRL_N_IO-1:0]                   gpio_oe_i,
  input  logic [`PAD_CTRL_N_IO-1:0]                   fpgaio_out_i,
  input  logic [`PAD_CTRL_N_IO-1:0]                   fpgaio_oe_i,
  input  logic [`PAD_CTRL_N_IO-1:0]                   io_in_i,
  output logic [`PAD_CTRL_N_IO-1:0]                   io_out_o,
  output logic [`PAD_CTRL_N_IO-1:0]                   io_oe_o,
  output logic [`PAD_CTRL_N_IO-1:0]                   perio_in_o,
  output logic [`PAD_CTRL_N_IO-1:0]                   gpio_in_o,
  output logic [`PAD_CTRL_N_IO-1:0]                   fpgaio_in_o
);

  // outgoing path, pad i takes bit i of its selected group
  always_comb begin
    io_out_o = '0;
    io_oe_o  = '0;
    for (int i = 0; i < `PAD_CTRL_N_IO; i++) begin
      case (pad_mux_i[i])
        pad_ctrl_pkg::MUX_PERIO: begin
          io_out_o[i] = perio_out_i[i];
          io_oe_o[i]  = perio_oe_i[i];
        end
        pad_ctrl_pkg::MUX_GPIO: begin
          io_out_o[i] = gpio_out_i[i];
          io_oe_o[i]  = gpio_oe_i[i];
        end
        pad_ctrl_pkg::MUX_FPGAIO: begin
          io_out_o[i] = fpgaio_out_i[i];
          io_oe_o[i]  = fpgaio_oe_i[i];
        end
        default: begin
          io_out_o[i] = 1'b0;
          io_oe_o[i]  = 1'b0;
        end
      endcase
    end
  end

  // incoming path, only the owning group sees the pad
  always_comb begin
    perio_in_o  = '0;
    gpio_in_o   = '0;
    fpgaio_in_o = '0;
    for (int i = 0; i < `PAD_CTRL_N_IO; i++) begin
      perio_in_o[i]  = (pad_mux_i[i] == pad_ctrl_pkg::MUX_PERIO)  & io_in_i[i];
      gpio_in_o[i]   = (pad_mux_i[i] == pad_ctrl_pkg::MUX_GPIO)   & io_in_i[i];
      fpgaio_in_o[i] = (pad_mux_i[i] == pad_ctrl_pkg::MUX_FPGAIO) & io_in_i[i];
    end
  end

endmodule

/* source/pad_ctrl.sv */
`timescale 1ns/1ps

`include "pad_ctrl_cfg.svh"

module pad_ctrl (
  input  logic                                              ref_clk_i,
  input  logic                                              rst_i,
  // config request / response
  input  logic                                              req_valid_i,
  input  pad_ctrl_pkg::cfg_req_t                            req_i,
  output logic                                              req_ready_o,
  output logic                                              rsp_valid_o,
  output pad_ctrl_pkg::cfg_rsp_t                            rsp_o,
  input  logic                                              rsp_ready_i,
  output logic [`PAD_CTRL_N_IO-1:0][`PAD_CTRL_NBIT_PADCFG-1:0] pad_cfg_o,
  // source groups
  input  logic [`PAD_CTRL_N_IO-1:0]                         perio_out_i,
  input  logic [`PAD_CTRL_N_IO-1:0]                         perio_oe_i,
  output logic [`PAD_CTRL_N_IO-1:0]                         perio_in_o,
  input  logic [`PAD_CTRL_N_IO-1:0]                         gpio_out_i,
  input  logic [`PAD_CTRL_N_IO-1:0]                         gpio_oe_i,
  output logic [`PAD_CTRL_N_IO-1:0]                         gpio_in_o,
  input  logic [`PAD_CTRL_N_IO-1:0]                         fpgaio_out_i,
  input  logic [`PAD_CTRL_N_IO-1:0]                         fpgaio_oe_i,
  output logic [`PAD_CTRL_N_IO-1:0]                         fpgaio_in_o,
  // pad side
  output logic [`PAD_CTRL_N_IO-1:0]                         io_out_o,
  output logic [`PAD_CTRL_N_IO-1:0]                         io_oe_o,
  input  logic [`PAD_CTRL_N_IO-1:0]                         io_in_i
);

  pad_ctrl_pkg::decoded_t                      s_dec;
  logic                                        s_rsp_pending;
  logic                                        s_rsp_accept;
  pad_ctrl_pkg::pad_mux_e [`PAD_CTRL_N_IO-1:0] s_pad_mux;

  pad_cfg_decode u_decode (
    .ref_clk_i     (ref_clk_i),
    .rst_i         (rst_i),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .req_ready_o   (req_ready_o),
    .rsp_pending_i (s_rsp_pending),
    .rsp_accept_i  (s_rsp_accept),
    .dec_o         (s_dec)
  );

  pad_cfg_regs u_regs (
    .ref_clk_i     (ref_clk_i),
    .rst_i         (rst_i),
    .dec_i         (s_dec),
    .rsp_ready_i   (rsp_ready_i),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_o         (rsp_o),
    .rsp_pending_o (s_rsp_pending),
    .rsp_accept_o  (s_rsp_accept),
    .pad_mux_o     (s_pad_mux),
    .pad_cfg_o     (pad_cfg_o)
  );

  pad_mux_route u_route (
    .pad_mux_i    (s_pad_mux),
    .perio_out_i  (perio_out_i),
    .perio_oe_i   (perio_oe_i),
    .gpio_out_i   (gpio_out_i),
    .gpio_oe_i    (gpio_oe_i),
    .fpgaio_out_i (fpgaio_out_i),
    .fpgaio_oe_i  (fpgaio_oe_i),
    .io_in_i      (io_in_i),
    .io_out_o     (io_out_o),
    .io_oe_o      (io_oe_o),
    .perio_in_o   (perio_in_o),
    .gpio_in_o    (gpio_in_o),
    .fpgaio_in_o  (fpgaio_in_o)
  );

endmodule

/* dv/pad_ctrl_checker.sv */
`timescale 1ns/1ps

`include "pad_ctrl_cfg.svh"

module pad_ctrl_checker (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  input  logic                                              req_valid_i,
  input  logic                                              req_ready_i,
  input  logic                                              rsp_valid_i,
  input  logic                                              rsp_ready_i,
  input  pad_ctrl_pkg::cfg_rsp_t                            rsp_i,
  input  logic [`PAD_CTRL_N_IO-1:0][`PAD_CTRL_NBIT_PADCFG-1:0] pad_cfg_i,
  input  logic [`PAD_CTRL_N_IO-1:0]                         io_out_i,
  input  logic [`PAD_CTRL_N_IO-1:0]                         io_oe_i,
  input  logic [`PAD_CTRL_N_IO-1:0]                         perio_in_i,
  input  logic [`PAD_CTRL_N_IO-1:0]                         gpio_in_i,
  input  logic [`PAD_CTRL_N_IO-1:0]                         fpgaio_in_i
);

  int pass_count = 0;
  int fail_count = 0;
  int proto_errors = 0;
  int step_errs = 0;

  logic                   stalled_q = 1'b0;
  logic                   accepted_q = 1'b0;
  pad_ctrl_pkg::cfg_rsp_t held_rsp_q;

  task automatic compare(input string name, input string field,
                         input logic [15:0] exp, input logic [15:0] act);
    if (exp !== act) begin
      $display("error %s %s: expected %h actual %h", name, field, exp, act);
      step_errs++;
    end
  endtask

  task automatic close_step(input string name);
    if (step_errs == 0) begin
      pass_count++;
      $display("pass %s", name);
    end else begin
      fail_count++;
    end
    step_errs = 0;
  endtask

  task automatic check_reset(input string name);
    compare(name, "req_ready_o", 16'd1, 16'(req_ready_i));
    compare(name, "rsp_valid_o", 16'd0, 16'(rsp_valid_i));
    compare(name, "io_out_o", 16'd0, io_out_i);
    compare(name, "io_oe_o", 16'd0, io_oe_i);
    compare(name, "perio_in_o", 16'd0, perio_in_i);
    compare(name, "gpio_in_o", 16'd0, gpio_in_i);
    compare(name, "fpgaio_in_o", 16'd0, fpgaio_in_i);
    for (int i = 0; i < `PAD_CTRL_N_IO; i++) begin
      compare(name, $sformatf("pad_cfg_o[%0d]", i), 16'd0, 16'(pad_cfg_i[i]));
    end
    close_step(name);
  endtask

  // called on the edge where the response is taken
  task automatic check_step(input string name, input logic [4:0] idx,
                            input logic [8:0] exp_rsp, input logic [15:0] exp_out,
                            input logic [15:0] exp_oe, input logic [15:0] exp_perio,
                            input logic [15:0] exp_gpio, input logic [15:0] exp_fpgaio);
    compare(name, "rsp_o", 16'(exp_rsp), 16'(rsp_i));
    compare(name, "io_out_o", exp_out, io_out_i);
    compare(name, "io_oe_o", exp_oe, io_oe_i);
    compare(name, "perio_in_o", exp_perio, perio_in_i);
    compare(name, "gpio_in_o", exp_gpio, gpio_in_i);
    compare(name, "fpgaio_in_o", exp_fpgaio, fpgaio_in_i);
    // stored config of the addressed pad matches the returned word
    if (!exp_rsp[8]) begin
      compare(name, "pad_cfg_o", 16'(exp_rsp[5:0]), 16'(pad_cfg_i[idx]));
    end
    close_step(name);
  endtask

  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (stalled_q && (!rsp_valid_i || rsp_i !== held_rsp_q)) begin
        $display("response was dropped or changed while the testbench stalled it");
        proto_errors++;
      end
      if (rsp_valid_i && !rsp_ready_i && req_ready_i) begin
        $display("request channel was ready while a response was stalled");
        proto_errors++;
      end
      if ((!rsp_valid_i || rsp_ready_i) && !req_ready_i) begin
        $display("request channel was not ready although no response was stalled");
        proto_errors++;
      end
      if (accepted_q && !rsp_valid_i) begin
        $display("no response one cycle after the request was accepted");
        proto_errors++;
      end
    end
    stalled_q  <= !rst_i && rsp_valid_i && !rsp_ready_i;
    accepted_q <= !rst_i && req_valid_i && req_ready_i;
    held_rsp_q <= rsp_i;
  end

  task automatic summary();
    $display("tests passed %0d, failed %0d, protocol errors %0d",
             pass_count, fail_count, proto_errors);
  endtask

  function automatic int failures();
    return fail_count + proto_errors;
  endfunction

endmodule

/* dv/tb_pad_ctrl.sv */
`timescale 1ns/1ps

`include "pad_ctrl_cfg.svh"

module tb_pad_ctrl;

  localparam int TIMEOUT = 100;

  logic ref_clk = 1'b0;
  logic rst_i = 1'b1;
  logic req_valid;
  logic req_ready;
  logic rsp_valid;
  logic rsp_ready;
  pad_ctrl_pkg::cfg_req_t req;
  pad_ctrl_pkg::cfg_rsp_t rsp;
  logic [`PAD_CTRL_N_IO-1:0][`PAD_CTRL_NBIT_PADCFG-1:0] pad_cfg;
  logic [`PAD_CTRL_N_IO-1:0] perio_out, perio_oe, gpio_out, gpio_oe, fpgaio_out, fpgaio_oe;
  logic [`PAD_CTRL_N_IO-1:0] io_in, io_out, io_oe, perio_in, gpio_in, fpgaio_in;

  logic [31:0] lcg_state = 32'd17801;
  bit          aborted = 1'b0;

  pad_ctrl u_pad_ctrl (
    .ref_clk_i    (ref_clk),    .rst_i        (rst_i),
    .req_valid_i  (req_valid),  .req_i        (req),
    .req_ready_o  (req_ready),  .rsp_valid_o  (rsp_valid),
    .rsp_o        (rsp),        .rsp_ready_i  (rsp_ready),
    .pad_cfg_o    (pad_cfg),
    .perio_out_i  (perio_out),  .perio_oe_i   (perio_oe),   .perio_in_o  (perio_in),
    .gpio_out_i   (gpio_out),   .gpio_oe_i    (gpio_oe),    .gpio_in_o   (gpio_in),
    .fpgaio_out_i (fpgaio_out), .fpgaio_oe_i  (fpgaio_oe),  .fpgaio_in_o (fpgaio_in),
    .io_out_o     (io_out),     .io_oe_o      (io_oe),      .io_in_i     (io_in)
  );

  pad_ctrl_checker u_checker (
    .clk_i       (ref_clk),   .rst_i       (rst_i),
    .req_valid_i (req_valid), .req_ready_i (req_ready),
    .rsp_valid_i (rsp_valid), .rsp_ready_i (rsp_ready),
    .rsp_i       (rsp),       .pad_cfg_i   (pad_cfg),
    .io_out_i    (io_out),    .io_oe_i     (io_oe),
    .perio_in_i  (perio_in),  .gpio_in_i   (gpio_in),
    .fpgaio_in_i (fpgaio_in)
  );

  always #10 ref_clk = ~ref_clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // entered right after a rising edge
  task automatic send_request(input pad_ctrl_pkg::cfg_req_t r);
    int cycles;
    cycles = 0;
    req_valid <= 1'b1;
    req       <= r;
    @(posedge ref_clk);
    while (!req_ready && cycles < TIMEOUT) begin
      @(posedge ref_clk);
      cycles++;
    end
    if (!req_ready) begin
      $display("timeout: request was never accepted");
      aborted = 1'b1;
    end
    req_valid <= 1'b0;
  endtask

  // random stalls on the response side
  task automatic await_response();
    int cycles;
    bit done;
    cycles = 0;
    done = 1'b0;
    while (!done && cycles < TIMEOUT) begin
      lcg_state = lcg_next(lcg_state);
      rsp_ready <= (lcg_state[17:16] != 2'd0);
      @(posedge ref_clk);
      cycles++;
      done = rsp_valid && rsp_ready;
    end
    if (!done) begin
      $display("timeout: no response was accepted");
      aborted = 1'b1;
    end
    rsp_ready <= 1'b0;
  endtask

  initial begin
    int fd, n, code;
    string line, name;
    logic [3:0] op, mux;
    logic [7:0] idx, cfg;
    logic [11:0] e_rsp;
    logic [15:0] po, poe, go, goe, fo, foe, pin, e_out, e_oe, e_pi, e_gi, e_fi;
    pad_ctrl_pkg::cfg_req_t r;

    req_valid = 1'b0;
    req = '0;
    rsp_ready = 1'b0;
    // busy sources while every pad is off
    {perio_out, perio_oe, gpio_out, gpio_oe} = {4{16'hffff}};
    {fpgaio_out, fpgaio_oe, io_in} = {3{16'hffff}};
    repeat (8) @(posedge ref_clk);
    rst_i <= 1'b0;
    @(posedge ref_clk);
    u_checker.check_reset("reset_defaults");

    fd = $fopen("dv/pad_ctrl_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file");
      aborted = 1'b1;
    end
    while (!aborted && !$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    name, op, idx, mux, cfg, po, poe, go, goe, fo, foe, pin,
                    e_rsp, e_out, e_oe, e_pi, e_gi, e_fi);
        if (n != 18) begin
          $display("malformed trace line: %s", line);
          aborted = 1'b1;
        end else begin
          r.op  = pad_ctrl_pkg::cfg_op_e'(op[0]);
          r.idx = idx[4:0];
          r.mux = pad_ctrl_pkg::pad_mux_e'(mux[1:0]);
          r.cfg = cfg[5:0];
          perio_out  <= po;
          perio_oe   <= poe;
          gpio_out   <= go;
          gpio_oe    <= goe;
          fpgaio_out <= fo;
          fpgaio_oe  <= foe;
          io_in      <= pin;
          send_request(r);
          if (!aborted) begin
            await_response();
          end
          if (!aborted) begin
            u_checker.check_step(name, r.idx, e_rsp[8:0], e_out, e_oe, e_pi, e_gi, e_fi);
          end
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    u_checker.summary();
    if (aborted || u_checker.failures() != 0) begin
      $display("Simulation failed");
    end else begin
      $display("Simulation completed successfully");
    end
    $finish;
  end

endmodule

/* dv/pad_ctrl_trace.txt */
# name op idx mux cfg perio_out perio_oe gpio_out gpio_oe fpgaio_out fpgaio_oe io_in
#   then expected rsp io_out io_oe perio_in gpio_in fpgaio_in (all hex)
wr_p0_perio   0 00 1 15 a5a5 0f0f 3c3c 00ff 5a5a ff00 c3c3 055 0001 0001 0001 0000 0000
wr_p1_gpio    0 01 2 2a a5a5 0f0f 3c3c 00ff 5a5a ff00 c3c3 0aa 0001 0003 0001 0002 0000
wr_p2_fpgaio  0 02 3 3f a5a5 0f0f 3c3c 00ff 5a5a ff00 c3c3 0ff 0001 0003 0001 0002 0000
wr_p15_perio  0 0f 1 01 a5a5 0f0f 3c3c 00ff 5a5a ff00 c3c3 041 8001 0003 8001 0002 0000
rd_p0         1 00 0 00 a5a5 0f0f 3c3c 00ff 5a5a ff00 c3c3 055 8001 0003 8001 0002 0000
rd_p2         1 02 0 00 a5a5 0f0f 3c3c 00ff 5a5a ff00 c3c3 0ff 8001 0003 8001 0002 0000
wr_bad_16     0 10 2 3f a5a5 0f0f 3c3c 00ff 5a5a ff00 c3c3 100 8001 0003 8001 0002 0000
rd_bad_31     1 1f 0 00 a5a5 0f0f 3c3c 00ff 5a5a ff00 c3c3 100 8001 0003 8001 0002 0000
rd_p15_kept   1 0f 0 00 a5a5 0f0f 3c3c 00ff 5a5a ff00 c3c3 041 8001 0003 8001 0002 0000
rd_p1_kept    1 01 0 00 a5a5 0f0f 3c3c 00ff 5a5a ff00 c3c3 0aa 8001 0003 8001 0002 0000
rd_p3_off     1 03 0 00 ffff ffff ffff ffff ffff ffff ffff 000 8007 8007 8001 0002 0004
wr_p3_gpio    0 03 2 07 ffff ffff ffff ffff ffff ffff ffff 087 800f 800f 8001 000a 0004
wr_p0_off     0 00 0 00 ffff ffff ffff ffff ffff ffff ffff 000 800e 800e 8000 000a 0004
rd_p0_off     1 00 0 00 0000 0000 ffff 0000 0000 0000 ffff 000 000a 0000 8000 000a 0004

/* verilog.f */
+incdir+include
source/pad_ctrl_pkg.sv
source/pad_cfg_decode.sv
source/pad_cfg_regs.sv
source/pad_mux_route.sv
source/pad_ctrl.sv
dv/pad_ctrl_checker.sv
dv/tb_pad_ctrl.sv

/* Bender.yml */
package:
  name: pad_ctrl

export_include_dirs:
  - include

sources:
  - source/pad_ctrl_pkg.sv
  - source/pad_cfg_decode.sv
  - source/pad_cfg_regs.sv
  - source/pad_mux_route.sv
  - source/pad_ctrl.sv
  - target: test
    files:
      - dv/pad_ctrl_checker.sv
      - dv/tb_pad_ctrl.sv
